/* mat_accel.f */
+incdir+.
mat_types_pkg.sv
mat_axil_pkg.sv
mat_scratchpad.sv
mat_mem_arbiter.sv
matrix_add_engine.sv
mat_host_port.sv
mat_accel_top.sv
tb_mat_accel.sv

/* tb_mat_accel.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mat_config.svh"

module tb_mat_accel import mat_types_pkg::*, mat_axil_pkg::*; ();

    localparam int TIMEOUT = 5000;
    localparam int POLL_LIMIT = 2000;

    logic      clk;
    logic      reset;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    logic      dut_busy;

    mat_data_t shadow [`MAT_MEM_DEPTH]; // Host view of the scratchpad.
    mat_addr_t exp_addr_q [$];
    mat_data_t exp_data_q [$];
    string     cur_test = "reset";
    int        errors = 0;
    logic      check_req = 1'b0;
    logic      run_done = 1'b0;

    mat_accel_top dut_i (
        .clk(clk), .reset(reset), .axil_req(axil_req), .axil_rsp(axil_rsp), .busy(dut_busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic axil_addr_t win_addr(input mat_addr_t idx);
        return `MAT_WIN_BASE + axil_addr_t'(4 * idx);
    endfunction

    // Element k of the result is the sum of element k of both sources, carry dropped.
    function automatic mat_data_t ref_add(input mat_addr_t s1, input mat_addr_t s2, input int k);
        logic [`MAT_DATA_W:0] full;
        full = {1'b0, shadow[s1 + mat_addr_t'(k)]} + {1'b0, shadow[s2 + mat_addr_t'(k)]};
        return full[`MAT_DATA_W-1:0];
    endfunction

    function automatic mat_data_t gen_data(input logic high);
        if (high) begin
            return mat_data_t'($urandom_range(32'hFFFF, 32'hFF00));
        end else begin
            return mat_data_t'($urandom);
        end
    endfunction

    task automatic end_run();
        run_done = 1'b1;
        $display("Run finished with %0d error(s)", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("ERROR: %s timed out waiting for %s", cur_test, what);
        end_run();
    endtask

    task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", what, exp, got);
        end
    endtask

    // The busy pin of the top level is sampled away from the rising edge.
    task automatic compare_busy(input logic exp);
        @(negedge clk);
        check_equal($sformatf("%s busy output", cur_test), 32'(exp), 32'(dut_busy));
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output axil_resp_t resp);
        int n;
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr <= addr;
        axil_req.wvalid <= 1'b1;
        axil_req.wdata <= data;
        axil_req.bready <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(axil_rsp.awready && axil_rsp.wready) && n < TIMEOUT);
        if (!(axil_rsp.awready && axil_rsp.wready)) begin
            report_timeout("the write address and data handshake");
        end
        @(posedge clk); // Address and data are taken at this edge.
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!axil_rsp.bvalid && n < TIMEOUT);
        if (!axil_rsp.bvalid) begin
            report_timeout("the write response");
        end
        resp = axil_rsp.bresp;
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_t resp);
        int n;
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr <= addr;
        axil_req.rready <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!axil_rsp.arready && n < TIMEOUT);
        if (!axil_rsp.arready) begin
            report_timeout("the read address handshake");
        end
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!axil_rsp.rvalid && n < TIMEOUT);
        if (!axil_rsp.rvalid) begin
            report_timeout("the read data");
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    task automatic write_word(input mat_addr_t idx, input mat_data_t data);
        axil_resp_t resp;
        axil_write(win_addr(idx), axil_data_t'(data), resp);
        shadow[idx] = data;
        check_equal($sformatf("%s write resp word 0x%0h", cur_test, idx), AXIL_OKAY, resp);
    endtask

    task automatic reg_write(input axil_addr_t addr, input axil_data_t data);
        axil_resp_t resp;
        axil_write(addr, data, resp);
        check_equal($sformatf("%s write resp reg 0x%0h", cur_test, addr), AXIL_OKAY, resp);
    endtask

    task automatic check_reg(input axil_addr_t addr, input axil_data_t exp);
        axil_data_t data;
        axil_resp_t resp;
        axil_read(addr, data, resp);
        check_equal($sformatf("%s reg 0x%0h", cur_test, addr), exp, data);
        check_equal($sformatf("%s read resp reg 0x%0h", cur_test, addr), AXIL_OKAY, resp);
    endtask

    task automatic queue_word(input mat_addr_t idx);
        exp_addr_q.push_back(idx);
        exp_data_q.push_back(shadow[idx]);
    endtask

    task automatic run_compare();
        int n;
        check_req = 1'b1;
        n = 0;
        while (check_req && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (check_req) begin
            report_timeout("the readback comparison");
        end
    endtask

    // Fills both sources, and the destination with one guard word on each side.
    task automatic load_job(input mat_addr_t s1, input mat_addr_t s2, input mat_addr_t d,
                            input int n, input logic high);
        for (int k = 0; k < n; k++) begin
            write_word(s1 + mat_addr_t'(k), gen_data(high));
            write_word(s2 + mat_addr_t'(k), gen_data(high));
        end
        for (int k = -1; k <= n; k++) begin
            write_word(d + mat_addr_t'(k), gen_data(1'b0));
        end
    endtask

    task automatic start_job(input mat_addr_t s1, input mat_addr_t s2, input mat_addr_t d,
                             input int rows, input int cols);
        reg_write(`MAT_REG_SRC1, axil_data_t'(s1));
        reg_write(`MAT_REG_SRC2, axil_data_t'(s2));
        reg_write(`MAT_REG_DEST, axil_data_t'(d));
        reg_write(`MAT_REG_DIMS, axil_data_t'((cols << `MAT_DIMS_COLS_LSB) | rows));
        reg_write(`MAT_REG_CTRL, 32'h1);
    endtask

    task automatic wait_idle();
        axil_data_t data;
        axil_resp_t resp;
        int polls;
        polls = 0;
        do begin
            axil_read(`MAT_REG_STATUS, data, resp);
            polls++;
        end while (data[0] && polls < POLL_LIMIT);
        if (data[0]) begin
            report_timeout("STATUS busy to clear");
        end
        compare_busy(1'b0);
    endtask

    task automatic verify_job(input mat_addr_t s1, input mat_addr_t s2, input mat_addr_t d,
                              input int span, input int n_done);
        for (int k = 0; k < n_done; k++) begin
            shadow[d + mat_addr_t'(k)] = ref_add(s1, s2, k);
        end
        for (int k = -1; k <= span; k++) begin
            queue_word(d + mat_addr_t'(k));
        end
        run_compare();
    endtask

    task automatic run_job(input mat_addr_t s1, input mat_addr_t s2, input mat_addr_t d,
                           input int rows, input int cols, input logic high);
        load_job(s1, s2, d, rows * cols, high);
        start_job(s1, s2, d, rows, cols);
        wait_idle();
        verify_job(s1, s2, d, rows * cols, rows * cols);
    endtask

    // Reads back every queued word through the window when the sequence asks for it.
    initial begin : compare_proc
        mat_addr_t  idx;
        mat_data_t  exp;
        axil_data_t got;
        axil_resp_t resp;
        while (!run_done) begin
            @(posedge clk);
            if (check_req) begin
                while (exp_addr_q.size() > 0) begin
                    idx = exp_addr_q.pop_front();
                    exp = exp_data_q.pop_front();
                    axil_read(win_addr(idx), got, resp);
                    check_equal($sformatf("%s word 0x%0h", cur_test, idx), 32'(exp), got);
                    check_equal($sformatf("%s read resp word 0x%0h", cur_test, idx),
                                AXIL_OKAY, resp);
                end
                check_req = 1'b0;
            end
        end
    end

    initial begin : main_seq
        int          rows;
        int          cols;
        mat_addr_t   base;
        axil_data_t  data;
        axil_resp_t  resp;
        void'($urandom(14));
        reset <= 1'b1;
        axil_req <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        cur_test = "readback";
        check_reg(`MAT_REG_STATUS, 32'h0);
        check_reg(`MAT_REG_CTRL, 32'h0);
        for (int i = 0; i < 8; i++) begin
            write_word(12'hE00 + mat_addr_t'(i), gen_data(1'b0));
            queue_word(12'hE00 + mat_addr_t'(i));
        end
        run_compare();
        reg_write(`MAT_REG_SRC1, 32'h123);
        reg_write(`MAT_REG_SRC2, 32'h456);
        reg_write(`MAT_REG_DEST, 32'h789);
        reg_write(`MAT_REG_DIMS, 32'h0A07);
        check_reg(`MAT_REG_SRC1, 32'h123);
        check_reg(`MAT_REG_SRC2, 32'h456);
        check_reg(`MAT_REG_DEST, 32'h789);
        check_reg(`MAT_REG_DIMS, 32'h0A07);

        for (int j = 0; j < 4; j++) begin
            cur_test = $sformatf("random job %0d", j);
            rows = (j == 0) ? 1 : (j == 3) ? 8 : int'($urandom_range(8, 1));
            cols = (j == 0) ? 1 : (j == 3) ? 8 : int'($urandom_range(8, 1));
            base = mat_addr_t'(12'h100 * (j + 1));
            run_job(base, base + 12'h40, base + 12'h81, rows, cols, 1'b0);
        end

        cur_test = "wrap";
        run_job(12'h500, 12'h540, 12'h581, 8, 8, 1'b1);

        cur_test = "busy access";
        load_job(12'h600, 12'h640, 12'h681, 64, 1'b0);
        write_word(12'hF80, gen_data(1'b0));
        start_job(12'h600, 12'h640, 12'h681, 8, 8);
        check_reg(`MAT_REG_STATUS, 32'h1);
        compare_busy(1'b1);
        reg_write(`MAT_REG_CTRL, 32'h1); // Must be dropped, the engine is busy.
        check_reg(`MAT_REG_CTRL, 32'h0);
        axil_read(win_addr(12'hF80), data, resp);
        check_equal("busy access word 0xf80", 32'(shadow[12'hF80]), data);
        wait_idle();
        verify_job(12'h600, 12'h640, 12'h681, 64, 64);

        cur_test = "zero rows";
        load_job(12'h700, 12'h740, 12'h781, 4, 1'b0);
        start_job(12'h700, 12'h740, 12'h781, 0, 4);
        wait_idle();
        verify_job(12'h700, 12'h740, 12'h781, 4, 0);
        cur_test = "zero cols";
        load_job(12'h800, 12'h840, 12'h881, 3, 1'b0);
        start_job(12'h800, 12'h840, 12'h881, 3, 0);
        wait_idle();
        verify_job(12'h800, 12'h840, 12'h881, 3, 0);

        cur_test = "unmapped";
        axil_write(16'h0018, 32'h1, resp);
        check_equal("unmapped write resp", AXIL_SLVERR, resp);
        axil_read(16'h0018, data, resp);
        check_equal("unmapped read data 0x18", 32'h0, data);
        check_equal("unmapped read resp 0x18", AXIL_SLVERR, resp);
        axil_read(16'hC000, data, resp); // First byte past the window.
        check_equal("unmapped read data 0xc000", 32'h0, data);
        check_equal("unmapped read resp 0xc000", AXIL_SLVERR, resp);

        end_run();
    end

endmodule

`default_nettype wire

/* mat_accel_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mat_accel_top import mat_types_pkg::*, mat_axil_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output logic      busy
);
    mem_req_t  eng_req;
    mem_req_t  host_req;
    mem_req_t  spm_req;
    mem_rsp_t  eng_rsp;
    mem_rsp_t  host_rsp;
    mem_rsp_t  spm_rsp;
    logic      eng_gnt;
    logic      host_gnt;
    logic      start;
    mat_addr_t src1_base;
    mat_addr_t src2_base;
    mat_addr_t dest_base;
    mat_dim_t  rows;
    mat_dim_t  cols;

    mat_host_port host_port_i (
        .clk(clk), .reset(reset),
        .axil_req(axil_req), .axil_rsp(axil_rsp),
        .mem_req(host_req), .mem_gnt(host_gnt), .mem_rsp(host_rsp),
        .start(start), .src1_base(src1_base), .src2_base(src2_base),
        .dest_base(dest_base), .rows(rows), .cols(cols), .busy(busy)
    );

    matrix_add_engine engine_i (
        .clk(clk), .reset(reset), .start(start),
        .src1_base(src1_base), .src2_base(src2_base), .dest_base(dest_base),
        .rows(rows), .cols(cols), .busy(busy),
        .mem_req(eng_req), .mem_gnt(eng_gnt), .mem_rsp(eng_rsp)
    );

    mat_mem_arbiter arbiter_i (
        .clk(clk), .reset(reset),
        .eng_req(eng_req), .host_req(host_req),
        .eng_gnt(eng_gnt), .host_gnt(host_gnt),
        .eng_rsp(eng_rsp), .host_rsp(host_rsp),
        .mem_req(spm_req), .mem_rsp(spm_rsp)
    );

    mat_scratchpad scratchpad_i (
        .clk(clk), .reset(reset), .req(spm_req), .rsp(spm_rsp)
    );

endmodule

`default_nettype wire

/* mat_host_port.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mat_config.svh"

module mat_host_port import mat_types_pkg::*, mat_axil_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output mem_req_t  mem_req,
    input  logic      mem_gnt,
    input  mem_rsp_t  mem_rsp,
    output logic      start,
    output mat_addr_t src1_base,
    output mat_addr_t src2_base,
    output mat_addr_t dest_base,
    output mat_dim_t  rows,
    output mat_dim_t  cols,
    input  logic      busy
);
    logic       bvalid_q;
    logic       rvalid_q;
    logic       mem_valid_q;
    logic       rd_wait_q;
    logic       start_q;
    logic       mem_write_q;
    mat_addr_t  mem_addr_q;
    mat_data_t  mem_wdata_q;
    axil_resp_t bresp_q;
    axil_resp_t rresp_q;
    axil_data_t rdata_q;
    axil_data_t reg_rdata;
    logic       idle;
    logic       wr_hs;
    logic       rd_hs;

    function automatic logic win_hit(input axil_addr_t addr);
        axil_addr_t off;
        off = addr - `MAT_WIN_BASE;
        return (addr >= `MAT_WIN_BASE) && (int'(off) < 4 * `MAT_MEM_DEPTH);
    endfunction

    function automatic mat_addr_t win_index(input axil_addr_t addr);
        axil_addr_t off;
        off = addr - `MAT_WIN_BASE;
        return off[2 +: `MAT_ADDR_W];
    endfunction

    function automatic logic reg_hit(input axil_addr_t addr);
        return addr inside {`MAT_REG_CTRL, `MAT_REG_STATUS, `MAT_REG_SRC1,
                            `MAT_REG_SRC2, `MAT_REG_DEST, `MAT_REG_DIMS};
    endfunction

    // Only one transaction at a time, and writes win over reads.
    assign idle = !bvalid_q && !rvalid_q && !mem_valid_q && !rd_wait_q;
    assign wr_hs = idle && axil_req.awvalid && axil_req.wvalid;
    assign rd_hs = idle && axil_req.arvalid && !(axil_req.awvalid && axil_req.wvalid);

    always_comb begin
        reg_rdata = '0; // CTRL and unmapped addresses read as zero.
        case (axil_req.araddr)
            `MAT_REG_STATUS: reg_rdata[0] = busy;
            `MAT_REG_SRC1: reg_rdata[`MAT_ADDR_W-1:0] = src1_base;
            `MAT_REG_SRC2: reg_rdata[`MAT_ADDR_W-1:0] = src2_base;
            `MAT_REG_DEST: reg_rdata[`MAT_ADDR_W-1:0] = dest_base;
            `MAT_REG_DIMS: begin
                reg_rdata[`MAT_DIM_W-1:0] = rows;
                reg_rdata[`MAT_DIMS_COLS_LSB +: `MAT_DIM_W] = cols;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            mem_valid_q <= 1'b0;
            rd_wait_q <= 1'b0;
            start_q <= 1'b0;
            src1_base <= '0;
            src2_base <= '0;
            dest_base <= '0;
            rows <= '0;
            cols <= '0;
        end else begin
            start_q <= 1'b0;
            if (bvalid_q && axil_req.bready) begin
                bvalid_q <= 1'b0;
            end
            if (rvalid_q && axil_req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (mem_valid_q && mem_gnt) begin
                mem_valid_q <= 1'b0;
                if (mem_write_q) begin
                    bvalid_q <= 1'b1;
                end else begin
                    rd_wait_q <= 1'b1;
                end
            end
            if (rd_wait_q && mem_rsp.valid) begin
                rd_wait_q <= 1'b0;
                rvalid_q <= 1'b1;
            end
            if (wr_hs) begin
                if (win_hit(axil_req.awaddr)) begin
                    mem_valid_q <= 1'b1;
                end else begin
                    bvalid_q <= 1'b1;
                    case (axil_req.awaddr)
                        `MAT_REG_CTRL: start_q <= axil_req.wdata[0] && !busy;
                        `MAT_REG_SRC1: src1_base <= axil_req.wdata[`MAT_ADDR_W-1:0];
                        `MAT_REG_SRC2: src2_base <= axil_req.wdata[`MAT_ADDR_W-1:0];
                        `MAT_REG_DEST: dest_base <= axil_req.wdata[`MAT_ADDR_W-1:0];
                        `MAT_REG_DIMS: begin
                            rows <= axil_req.wdata[`MAT_DIM_W-1:0];
                            cols <= axil_req.wdata[`MAT_DIMS_COLS_LSB +: `MAT_DIM_W];
                        end
                        default: ;
                    endcase
                end
            end else if (rd_hs) begin
                if (win_hit(axil_req.araddr)) begin
                    mem_valid_q <= 1'b1;
                end else begin
                    rvalid_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            mem_write_q <= 1'b1;
            mem_addr_q <= win_index(axil_req.awaddr);
            mem_wdata_q <= axil_req.wdata[`MAT_DATA_W-1:0];
            bresp_q <= (win_hit(axil_req.awaddr) || reg_hit(axil_req.awaddr)) ?
                       AXIL_OKAY : AXIL_SLVERR;
        end else if (rd_hs) begin
            mem_write_q <= 1'b0;
            mem_addr_q <= win_index(axil_req.araddr);
            rdata_q <= reg_rdata;
            rresp_q <= (win_hit(axil_req.araddr) || reg_hit(axil_req.araddr)) ?
                       AXIL_OKAY : AXIL_SLVERR;
        end
        if (rd_wait_q && mem_rsp.valid) begin
            rdata_q <= axil_data_t'(mem_rsp.rdata);
        end
    end

    assign mem_req = '{valid: mem_valid_q, write: mem_write_q, addr: mem_addr_q,
                       wdata: mem_wdata_q};
    assign start = start_q;

    assign axil_rsp = '{awready: wr_hs, wready: wr_hs, bvalid: bvalid_q, bresp: bresp_q,
                        arready: rd_hs, rvalid: rvalid_q, rdata: rdata_q, rresp: rresp_q};

    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        bvalid_q && !axil_req.bready |=> bvalid_q);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
        rvalid_q && !axil_req.rready |=> rvalid_q);

endmodule

`default_nettype wire

/* matrix_add_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module matrix_add_engine import mat_types_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  mat_addr_t src1_base,
    input  mat_addr_t src2_base,
    input  mat_addr_t dest_base,
    input  mat_dim_t  rows,
    input  mat_dim_t  cols,
    output logic      busy,
    output mem_req_t  mem_req,
    input  logic      mem_gnt,
    input  mem_rsp_t  mem_rsp
);
    add_state_t state;
    logic       busy_q;
    mat_count_t idx;
    mat_count_t last_idx;
    mat_addr_t  src1_q;
    mat_addr_t  src2_q;
    mat_addr_t  dest_q;
    mat_data_t  a_q;
    mat_data_t  sum_q;
    logic       last_elem;
    logic       empty_job;

    assign empty_job = (rows == '0) || (cols == '0);
    assign last_elem = (idx == last_idx);
    assign busy = busy_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            busy_q <= 1'b0;
            idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    busy_q <= start; // An empty job stays busy for this one cycle.
                    idx <= '0;
                    if (start && !empty_job) begin
                        state <= READ_A;
                    end
                end
                READ_A: begin
                    if (mem_gnt) begin
                        state <= WAIT_A;
                    end
                end
                WAIT_A: begin
                    if (mem_rsp.valid) begin
                        state <= READ_B;
                    end
                end
                READ_B: begin
                    if (mem_gnt) begin
                        state <= WAIT_B;
                    end
                end
                WAIT_B: begin
                    if (mem_rsp.valid) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (mem_gnt) begin
                        if (last_elem) begin
                            state <= IDLE;
                            busy_q <= 1'b0;
                        end else begin
                            idx <= idx + 1'b1;
                            state <= READ_A;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                    busy_q <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            src1_q <= src1_base;
            src2_q <= src2_base;
            dest_q <= dest_base;
            last_idx <= mat_count_t'(rows) * mat_count_t'(cols) - 1'b1;
        end
        if (state == WAIT_A && mem_rsp.valid) begin
            a_q <= mem_rsp.rdata;
        end
        if (state == WAIT_B && mem_rsp.valid) begin
            sum_q <= a_q + mem_rsp.rdata; // Wraps modulo 2^16.
        end
    end

    // Row-major walk, so element k sits at base + k in every matrix.
    always_comb begin
        mem_req = '0;
        case (state)
            READ_A: begin
                mem_req.valid = 1'b1;
                mem_req.addr = src1_q + mat_addr_t'(idx);
            end
            READ_B: begin
                mem_req.valid = 1'b1;
                mem_req.addr = src2_q + mat_addr_t'(idx);
            end
            WRITE: begin
                mem_req.valid = 1'b1;
                mem_req.write = 1'b1;
                mem_req.addr = dest_q + mat_addr_t'(idx);
                mem_req.wdata = sum_q;
            end
            default: ;
        endcase
    end

    a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
        state == IDLE |-> !mem_req.valid);

    // The host port must hold back a start while a job runs.
    a_no_start_when_busy: assert property (@(posedge clk) disable iff (reset)
        start |-> !busy_q);

endmodule

`default_nettype wire

/* mat_mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mat_mem_arbiter import mat_types_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t eng_req,
    input  mem_req_t host_req,
    output logic     eng_gnt,
    output logic     host_gnt,
    output mem_rsp_t eng_rsp,
    output mem_rsp_t host_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);
    logic rd_eng_q; // Owner of the read accepted last cycle.

    // The engine always wins; the host only gets the slot it leaves free.
    assign eng_gnt = eng_req.valid;
    assign host_gnt = host_req.valid && !eng_req.valid;

    always_comb begin
        if (eng_gnt) begin
            mem_req = eng_req;
        end else if (host_gnt) begin
            mem_req = host_req;
        end else begin
            mem_req = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_eng_q <= 1'b0;
        end else if (mem_req.valid && !mem_req.write) begin
            rd_eng_q <= eng_gnt;
        end
    end

    always_comb begin
        eng_rsp.rdata = mem_rsp.rdata;
        host_rsp.rdata = mem_rsp.rdata;
        eng_rsp.valid = mem_rsp.valid && rd_eng_q;
        host_rsp.valid = mem_rsp.valid && !rd_eng_q;
    end

    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        !(eng_gnt && host_gnt));

    // Read data must only come back for a read that was forwarded.
    a_rsp_follows_read: assert property (@(posedge clk) disable iff (reset)
        mem_rsp.valid |-> $past(mem_req.valid && !mem_req.write));

endmodule

`default_nettype wire

/* mat_scratchpad.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mat_config.svh"

module mat_scratchpad import mat_types_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t req,
    output mem_rsp_t rsp
);
    mat_data_t mem [`MAT_MEM_DEPTH];
    logic      rd_valid_q;
    mat_data_t rd_data_q;

    always_ff @(posedge clk) begin
        if (req.valid && req.write) begin
            mem[req.addr] <= req.wdata;
        end
        if (req.valid && !req.write) begin
            rd_data_q <= mem[req.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= req.valid && !req.write; // Data follows one cycle later.
        end
    end

    assign rsp = '{valid: rd_valid_q, rdata: rd_data_q};

    a_addr_in_range: assert property (@(posedge clk) disable iff (reset)
        req.valid |-> !$isunknown(req.addr) && (int'(req.addr) < `MAT_MEM_DEPTH));

endmodule

`default_nettype wire

/* mat_axil_pkg.sv */
`default_nettype none

`include "mat_config.svh"

package mat_axil_pkg;

    typedef logic [`MAT_AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [`MAT_AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t AXIL_OKAY = 2'b00;
    localparam axil_resp_t AXIL_SLVERR = 2'b10;

    typedef struct packed {
        logic       awvalid;
        axil_addr_t awaddr;
        logic       wvalid;
        axil_data_t wdata;
        logic       bready;
        logic       arvalid;
        axil_addr_t araddr;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

/* mat_types_pkg.sv */
`default_nettype none

`include "mat_config.svh"

package mat_types_pkg;

    typedef logic [`MAT_ADDR_W-1:0] mat_addr_t;
    typedef logic [`MAT_DATA_W-1:0] mat_data_t;
    typedef logic [`MAT_DIM_W-1:0] mat_dim_t;
    typedef logic [2*`MAT_DIM_W-1:0] mat_count_t; // Holds rows * cols.

    typedef struct packed {
        logic      valid;
        logic      write;
        mat_addr_t addr;
        mat_data_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic      valid;
        mat_data_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_A,
        WAIT_A,
        READ_B,
        WAIT_B,
        WRITE
    } add_state_t;

endpackage

`default_nettype wire

/* mat_config.svh */
`ifndef MAT_CONFIG_SVH
`define MAT_CONFIG_SVH

`define MAT_ADDR_W 12
`define MAT_DATA_W 16
`define MAT_DIM_W 6
`define MAT_MEM_DEPTH 4096

// Bit position of the column count in the DIMS register.
`define MAT_DIMS_COLS_LSB 8

`define MAT_AXIL_ADDR_W 16
`define MAT_AXIL_DATA_W 32

`define MAT_REG_CTRL 16'h0000
`define MAT_REG_STATUS 16'h0004
`define MAT_REG_SRC1 16'h0008
`define MAT_REG_SRC2 16'h000C
`define MAT_REG_DEST 16'h0010
`define MAT_REG_DIMS 16'h0014

// Word n of the scratchpad sits at MAT_WIN_BASE + 4 * n.
`define MAT_WIN_BASE 16'h8000

`endif
